// ==== hdl/ooo_pkg.sv ====
package ooo_pkg;

    // default core sizes
    parameter int xlen_p      = 16;
    parameter int arch_regs_p = 8;
    parameter int phys_regs_p = 16;
    parameter int rob_sz_p    = 8;
    parameter int rs_sz_p     = 4;
    parameter int mult_lat_p  = 3;

    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_XOR,
        // result is the immediate
        OP_LI,
        // keeps the low xlen_p bits of the product
        OP_MUL
    } alu_op_e;

    typedef enum logic {
        FU_ALU,
        FU_MULT
    } fu_e;

endpackage

// ==== hdl/rat.sv ====
`timescale 1ns/1ns
module rat #(
    parameter int arch_regs_p = ooo_pkg::arch_regs_p,
    parameter int phys_regs_p = ooo_pkg::phys_regs_p,
    localparam int arn_w = $clog2(arch_regs_p),
    localparam int prn_w = $clog2(phys_regs_p)
) (
    input  logic             clock,
    input  logic             rst_n,
    input  logic             alloc,
    input  logic [arn_w-1:0] src1_arn, src2_arn, dest_arn,
    output logic [prn_w-1:0] op1_prn, op2_prn, dest_prn,
    input  logic             free_valid,
    input  logic [prn_w-1:0] free_prn
);
    localparam int fl_sz = phys_regs_p - arch_regs_p;
    localparam int fl_w  = $clog2(fl_sz);
    localparam int cnt_w = fl_w + 1;

    logic [prn_w-1:0] map       [arch_regs_p];
    logic [prn_w-1:0] free_list [fl_sz];
    logic [fl_w-1:0]  head, tail;
    logic [cnt_w-1:0] count;

    assign op1_prn  = map[src1_arn];
    assign op2_prn  = map[src2_arn];
    assign dest_prn = free_list[head];

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < arch_regs_p; r++) begin
                map[r] <= prn_w'(r);
            end
            // registers above the architectural ones start out free
            for (int i = 0; i < fl_sz; i++) begin
                free_list[i] <= prn_w'(arch_regs_p + i);
            end
            head  <= '0;
            tail  <= '0;
            count <= cnt_w'(fl_sz);
        end else begin
            if (alloc) begin
                head <= (head == fl_w'(fl_sz - 1)) ? '0 : head + 1'b1;
                // r0 stays on p0
                if (dest_arn != '0) begin
                    map[dest_arn] <= dest_prn;
                end
            end
            if (free_valid) begin
                free_list[tail] <= free_prn;
                tail            <= (tail == fl_w'(fl_sz - 1)) ? '0 : tail + 1'b1;
            end
            count <= count + cnt_w'(free_valid) - cnt_w'(alloc);
        end
    end

    a_free_list_underflow: assert property (@(posedge clock) disable iff (!rst_n)
        alloc |-> count != '0);

endmodule

// ==== hdl/rrat.sv ====
`timescale 1ns/1ns
module rrat #(
    parameter int arch_regs_p = ooo_pkg::arch_regs_p,
    parameter int phys_regs_p = ooo_pkg::phys_regs_p,
    localparam int arn_w = $clog2(arch_regs_p),
    localparam int prn_w = $clog2(phys_regs_p)
) (
    input  logic             clock,
    input  logic             rst_n,
    input  logic             commit,
    input  logic [arn_w-1:0] commit_arn,
    input  logic [prn_w-1:0] commit_prn,
    output logic             free_valid,
    output logic [prn_w-1:0] free_prn
);
    logic [prn_w-1:0] map [arch_regs_p];

    assign free_valid = commit;
    // r0 keeps no mapping, its fresh register goes straight back
    assign free_prn   = (commit_arn == '0) ? commit_prn : map[commit_arn];

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < arch_regs_p; r++) begin
                map[r] <= prn_w'(r);
            end
        end else if (commit && commit_arn != '0) begin
            map[commit_arn] <= commit_prn;
        end
    end

endmodule

// ==== hdl/prf.sv ====
`timescale 1ns/1ns
module prf #(
    parameter int xlen_p      = ooo_pkg::xlen_p,
    parameter int phys_regs_p = ooo_pkg::phys_regs_p,
    localparam int prn_w = $clog2(phys_regs_p)
) (
    input  logic              clock,
    input  logic              rst_n,
    input  logic [prn_w-1:0]  rd1_prn, rd2_prn,
    output logic [xlen_p-1:0] rd1_value, rd2_value,
    output logic              rd1_ready, rd2_ready,
    input  logic              alloc,
    input  logic [prn_w-1:0]  alloc_prn,
    input  logic              cdb_valid,
    input  logic [prn_w-1:0]  cdb_prn,
    input  logic [xlen_p-1:0] cdb_value,
    input  logic [prn_w-1:0]  ct_prn,
    output logic [xlen_p-1:0] ct_value
);
    logic [xlen_p-1:0]      value [phys_regs_p];
    logic [phys_regs_p-1:0] ready;

    assign rd1_value = value[rd1_prn];
    assign rd2_value = value[rd2_prn];
    assign rd1_ready = ready[rd1_prn];
    assign rd2_ready = ready[rd2_prn];
    assign ct_value  = value[ct_prn];

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < phys_regs_p; i++) begin
                value[i] <= '0;
            end
            ready <= '1;
        end else begin
            if (cdb_valid) begin
                value[cdb_prn] <= cdb_value;
                ready[cdb_prn] <= 1'b1;
            end
            // new destination waits for its broadcast
            if (alloc) begin
                ready[alloc_prn] <= 1'b0;
            end
        end
    end

endmodule

// ==== hdl/rs.sv ====
`timescale 1ns/1ns
module rs #(
    parameter int xlen_p      = ooo_pkg::xlen_p,
    parameter int phys_regs_p = ooo_pkg::phys_regs_p,
    parameter int rob_sz_p    = ooo_pkg::rob_sz_p,
    parameter int rs_sz_p     = ooo_pkg::rs_sz_p,
    localparam int prn_w  = $clog2(phys_regs_p),
    localparam int robn_w = $clog2(rob_sz_p)
) (
    input  logic              clock,
    input  logic              rst_n,
    input  logic              disp,
    input  ooo_pkg::alu_op_e  disp_op,
    input  logic              disp_op1_ready, disp_op2_ready,
    input  logic [xlen_p-1:0] disp_op1, disp_op2,
    input  logic [prn_w-1:0]  disp_dest_prn,
    input  logic [robn_w-1:0] disp_robn,
    input  logic              cdb_valid,
    input  logic [prn_w-1:0]  cdb_prn,
    input  logic [xlen_p-1:0] cdb_value,
    input  logic              alu_avail, mult_avail,
    output logic              alu_issue,
    output ooo_pkg::alu_op_e  alu_op,
    output logic [xlen_p-1:0] alu_a, alu_b,
    output logic [prn_w-1:0]  alu_dest_prn,
    output logic [robn_w-1:0] alu_robn,
    output logic              mult_issue,
    output logic [xlen_p-1:0] mult_a, mult_b,
    output logic [prn_w-1:0]  mult_dest_prn,
    output logic [robn_w-1:0] mult_robn,
    output logic              full
);
    localparam int idx_w = $clog2(rs_sz_p);

    logic [rs_sz_p-1:0] valid, rdy1, rdy2;
    ooo_pkg::alu_op_e   op   [rs_sz_p];
    ooo_pkg::fu_e       fu   [rs_sz_p];
    logic [xlen_p-1:0]  opa  [rs_sz_p];
    logic [xlen_p-1:0]  opb  [rs_sz_p];
    logic [prn_w-1:0]   dest [rs_sz_p];
    logic [robn_w-1:0]  robn [rs_sz_p];
    // 0 is the oldest, valid entries keep distinct ages
    logic [idx_w-1:0]   age  [rs_sz_p];
    logic [idx_w-1:0]   alu_sel, mult_sel, free_sel, n_left;
    logic               cap1, cap2;

    assign full = &valid;

    // operand produced on the CDB in the dispatch cycle
    assign cap1 = !disp_op1_ready && cdb_valid && disp_op1[prn_w-1:0] == cdb_prn;
    assign cap2 = !disp_op2_ready && cdb_valid && disp_op2[prn_w-1:0] == cdb_prn;

    always_comb begin
        alu_issue  = 1'b0;
        mult_issue = 1'b0;
        alu_sel    = '0;
        mult_sel   = '0;
        free_sel   = '0;
        for (int i = rs_sz_p - 1; i >= 0; i--) begin
            if (!valid[i]) begin
                free_sel = idx_w'(i);
            end
        end
        for (int i = 0; i < rs_sz_p; i++) begin
            if (valid[i] && rdy1[i] && rdy2[i]) begin
                if (fu[i] == ooo_pkg::FU_ALU && alu_avail
                        && (!alu_issue || age[i] < age[alu_sel])) begin
                    alu_issue = 1'b1;
                    alu_sel   = idx_w'(i);
                end
                if (fu[i] == ooo_pkg::FU_MULT && mult_avail
                        && (!mult_issue || age[i] < age[mult_sel])) begin
                    mult_issue = 1'b1;
                    mult_sel   = idx_w'(i);
                end
            end
        end
        // entries still held after this cycle's issue
        n_left = idx_w'($countones(valid)) - idx_w'(alu_issue) - idx_w'(mult_issue);
    end

    assign alu_op        = op[alu_sel];
    assign alu_a         = opa[alu_sel];
    assign alu_b         = opb[alu_sel];
    assign alu_dest_prn  = dest[alu_sel];
    assign alu_robn      = robn[alu_sel];
    assign mult_a        = opa[mult_sel];
    assign mult_b        = opb[mult_sel];
    assign mult_dest_prn = dest[mult_sel];
    assign mult_robn     = robn[mult_sel];

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            valid <= '0;
        end else begin
            if (alu_issue) begin
                valid[alu_sel] <= 1'b0;
            end
            if (mult_issue) begin
                valid[mult_sel] <= 1'b0;
            end
            if (disp) begin
                valid[free_sel] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < rs_sz_p; i++) begin
            age[i] <= age[i] - idx_w'(alu_issue && age[alu_sel] < age[i])
                             - idx_w'(mult_issue && age[mult_sel] < age[i]);
            // wakeup on tag match
            if (cdb_valid && !rdy1[i] && opa[i][prn_w-1:0] == cdb_prn) begin
                rdy1[i] <= 1'b1;
                opa[i]  <= cdb_value;
            end
            if (cdb_valid && !rdy2[i] && opb[i][prn_w-1:0] == cdb_prn) begin
                rdy2[i] <= 1'b1;
                opb[i]  <= cdb_value;
            end
        end
        if (disp) begin
            op[free_sel]   <= disp_op;
            fu[free_sel]   <= (disp_op == ooo_pkg::OP_MUL) ? ooo_pkg::FU_MULT : ooo_pkg::FU_ALU;
            rdy1[free_sel] <= disp_op1_ready || cap1;
            rdy2[free_sel] <= disp_op2_ready || cap2;
            opa[free_sel]  <= cap1 ? cdb_value : disp_op1;
            opb[free_sel]  <= cap2 ? cdb_value : disp_op2;
            dest[free_sel] <= disp_dest_prn;
            robn[free_sel] <= disp_robn;
            age[free_sel]  <= n_left;
        end
    end

    a_disp_not_full: assert property (@(posedge clock) disable iff (!rst_n)
        disp |-> !full);

endmodule

// ==== hdl/rob.sv ====
`timescale 1ns/1ns
module rob #(
    parameter int arch_regs_p = ooo_pkg::arch_regs_p,
    parameter int phys_regs_p = ooo_pkg::phys_regs_p,
    parameter int rob_sz_p    = ooo_pkg::rob_sz_p,
    localparam int arn_w  = $clog2(arch_regs_p),
    localparam int prn_w  = $clog2(phys_regs_p),
    localparam int robn_w = $clog2(rob_sz_p)
) (
    input  logic              clock,
    input  logic              rst_n,
    input  logic              disp,
    input  logic [arn_w-1:0]  disp_arn,
    input  logic [prn_w-1:0]  disp_prn,
    output logic [robn_w-1:0] tail_robn,
    input  logic              cdb_valid,
    input  logic [robn_w-1:0] cdb_robn,
    output logic              ct_valid,
    output logic [arn_w-1:0]  ct_arn,
    output logic [prn_w-1:0]  ct_prn,
    output logic              full
);
    localparam int cnt_w = robn_w + 1;

    logic [arn_w-1:0]    arn [rob_sz_p];
    logic [prn_w-1:0]    prn [rob_sz_p];
    logic [rob_sz_p-1:0] executed;
    // rob_sz_p is a power of two, pointers wrap by themselves
    logic [robn_w-1:0]   head, tail;
    logic [cnt_w-1:0]    count;

    assign tail_robn = tail;
    assign full      = count == cnt_w'(rob_sz_p);
    assign ct_valid  = (count != '0) && executed[head];
    assign ct_arn    = arn[head];
    assign ct_prn    = prn[head];

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            head     <= '0;
            tail     <= '0;
            count    <= '0;
            executed <= '0;
        end else begin
            if (cdb_valid) begin
                executed[cdb_robn] <= 1'b1;
            end
            if (disp) begin
                executed[tail] <= 1'b0;
                tail           <= tail + 1'b1;
            end
            if (ct_valid) begin
                head <= head + 1'b1;
            end
            count <= count + cnt_w'(disp) - cnt_w'(ct_valid);
        end
    end

    always_ff @(posedge clock) begin
        if (disp) begin
            arn[tail] <= disp_arn;
            prn[tail] <= disp_prn;
        end
    end

    // broadcast tag must lie between head and tail
    a_cdb_in_flight: assert property (@(posedge clock) disable iff (!rst_n)
        cdb_valid |-> robn_w'(cdb_robn - head) < count);

endmodule

// ==== hdl/fu_cdb.sv ====
`timescale 1ns/1ns
module fu_cdb #(
    parameter int xlen_p      = ooo_pkg::xlen_p,
    parameter int phys_regs_p = ooo_pkg::phys_regs_p,
    parameter int rob_sz_p    = ooo_pkg::rob_sz_p,
    parameter int mult_lat_p  = ooo_pkg::mult_lat_p,
    localparam int prn_w  = $clog2(phys_regs_p),
    localparam int robn_w = $clog2(rob_sz_p)
) (
    input  logic              clock,
    input  logic              rst_n,
    input  logic              alu_issue,
    input  ooo_pkg::alu_op_e  alu_op,
    input  logic [xlen_p-1:0] alu_a, alu_b,
    input  logic [prn_w-1:0]  alu_dest_prn,
    input  logic [robn_w-1:0] alu_robn,
    input  logic              mult_issue,
    input  logic [xlen_p-1:0] mult_a, mult_b,
    input  logic [prn_w-1:0]  mult_dest_prn,
    input  logic [robn_w-1:0] mult_robn,
    output logic              alu_avail, mult_avail,
    output logic              cdb_valid,
    output logic [prn_w-1:0]  cdb_prn,
    output logic [robn_w-1:0] cdb_robn,
    output logic [xlen_p-1:0] cdb_value
);
    // the CDB register is the last stage of the multiplier
    localparam int st_n = mult_lat_p - 1;

    logic [st_n-1:0]   m_valid;
    logic [xlen_p-1:0] m_prod [st_n];
    logic [prn_w-1:0]  m_prn  [st_n];
    logic [robn_w-1:0] m_robn [st_n];
    logic              m_done;
    logic [xlen_p-1:0] alu_result;

    assign m_done     = m_valid[st_n-1];
    // keep the CDB slot free for a landing product
    assign alu_avail  = !m_done;
    // fully pipelined
    assign mult_avail = 1'b1;

    always_comb begin
        case (alu_op)
            ooo_pkg::OP_ADD: alu_result = alu_a + alu_b;
            ooo_pkg::OP_SUB: alu_result = alu_a - alu_b;
            ooo_pkg::OP_AND: alu_result = alu_a & alu_b;
            ooo_pkg::OP_XOR: alu_result = alu_a ^ alu_b;
            // li, immediate sits in b
            default:         alu_result = alu_b;
        endcase
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            m_valid   <= '0;
            cdb_valid <= 1'b0;
        end else begin
            m_valid[0] <= mult_issue;
            for (int s = 1; s < st_n; s++) begin
                m_valid[s] <= m_valid[s-1];
            end
            cdb_valid <= m_done || alu_issue;
        end
    end

    always_ff @(posedge clock) begin
        m_prod[0] <= mult_a * mult_b;
        m_prn[0]  <= mult_dest_prn;
        m_robn[0] <= mult_robn;
        for (int s = 1; s < st_n; s++) begin
            m_prod[s] <= m_prod[s-1];
            m_prn[s]  <= m_prn[s-1];
            m_robn[s] <= m_robn[s-1];
        end
        if (m_done) begin
            cdb_prn   <= m_prn[st_n-1];
            cdb_robn  <= m_robn[st_n-1];
            cdb_value <= m_prod[st_n-1];
        end else begin
            cdb_prn   <= alu_dest_prn;
            cdb_robn  <= alu_robn;
            cdb_value <= alu_result;
        end
    end

    a_one_cdb_winner: assert property (@(posedge clock) disable iff (!rst_n)
        !(alu_issue && m_done));

endmodule

// ==== hdl/ooo.sv ====
`timescale 1ns/1ns
module ooo #(
    parameter int xlen_p      = ooo_pkg::xlen_p,
    parameter int arch_regs_p = ooo_pkg::arch_regs_p,
    parameter int phys_regs_p = ooo_pkg::phys_regs_p,
    parameter int rob_sz_p    = ooo_pkg::rob_sz_p,
    parameter int rs_sz_p     = ooo_pkg::rs_sz_p,
    parameter int mult_lat_p  = ooo_pkg::mult_lat_p,
    localparam int arn_w = $clog2(arch_regs_p)
) (
    input  logic              clock,
    input  logic              rst_n,
    input  logic              in_valid,
    input  ooo_pkg::alu_op_e  in_op,
    input  logic [arn_w-1:0]  in_dest, in_src1, in_src2,
    input  logic [xlen_p-1:0] in_imm,
    output logic              structural_hazard,
    output logic              ct_valid, ct_wr_en,
    output logic [arn_w-1:0]  ct_arn,
    output logic [xlen_p-1:0] ct_value
);
    localparam int prn_w  = $clog2(phys_regs_p);
    localparam int robn_w = $clog2(rob_sz_p);

    logic              disp, rs_full, rob_full, free_valid;
    logic [prn_w-1:0]  op1_prn, op2_prn, dest_prn, free_prn, ct_prn;
    logic [xlen_p-1:0] rd1_value, rd2_value, disp_op1, disp_op2;
    logic              rd1_ready, rd2_ready, disp_op1_ready, disp_op2_ready;
    logic [robn_w-1:0] tail_robn, alu_robn, mult_robn, cdb_robn;
    logic              alu_avail, mult_avail, alu_issue, mult_issue, cdb_valid;
    ooo_pkg::alu_op_e  alu_op;
    logic [xlen_p-1:0] alu_a, alu_b, mult_a, mult_b, cdb_value;
    logic [prn_w-1:0]  alu_dest_prn, mult_dest_prn, cdb_prn;

    assign structural_hazard = rs_full || rob_full;
    assign disp              = in_valid && !structural_hazard;
    assign ct_wr_en          = ct_valid && (ct_arn != '0);

    always_comb begin
        // a waiting operand carries the producer tag
        disp_op1_ready = rd1_ready;
        disp_op2_ready = rd2_ready;
        disp_op1       = rd1_ready ? rd1_value : xlen_p'(op1_prn);
        disp_op2       = rd2_ready ? rd2_value : xlen_p'(op2_prn);
        if (in_op == ooo_pkg::OP_LI) begin
            disp_op1_ready = 1'b1;
            disp_op2_ready = 1'b1;
            disp_op1       = '0;
            disp_op2       = in_imm;
        end
    end

    rat #(.arch_regs_p(arch_regs_p), .phys_regs_p(phys_regs_p)) u_rat (
        .clock(clock), .rst_n(rst_n), .alloc(disp),
        .src1_arn(in_src1), .src2_arn(in_src2), .dest_arn(in_dest),
        .op1_prn(op1_prn), .op2_prn(op2_prn), .dest_prn(dest_prn),
        .free_valid(free_valid), .free_prn(free_prn)
    );

    rrat #(.arch_regs_p(arch_regs_p), .phys_regs_p(phys_regs_p)) u_rrat (
        .clock(clock), .rst_n(rst_n),
        .commit(ct_valid), .commit_arn(ct_arn), .commit_prn(ct_prn),
        .free_valid(free_valid), .free_prn(free_prn)
    );

    prf #(.xlen_p(xlen_p), .phys_regs_p(phys_regs_p)) u_prf (
        .clock(clock), .rst_n(rst_n),
        .rd1_prn(op1_prn), .rd2_prn(op2_prn),
        .rd1_value(rd1_value), .rd2_value(rd2_value),
        .rd1_ready(rd1_ready), .rd2_ready(rd2_ready),
        .alloc(disp), .alloc_prn(dest_prn),
        .cdb_valid(cdb_valid), .cdb_prn(cdb_prn), .cdb_value(cdb_value),
        .ct_prn(ct_prn), .ct_value(ct_value)
    );

    rs #(
        .xlen_p(xlen_p), .phys_regs_p(phys_regs_p),
        .rob_sz_p(rob_sz_p), .rs_sz_p(rs_sz_p)
    ) u_rs (
        .clock(clock), .rst_n(rst_n), .disp(disp), .disp_op(in_op),
        .disp_op1_ready(disp_op1_ready), .disp_op2_ready(disp_op2_ready),
        .disp_op1(disp_op1), .disp_op2(disp_op2),
        .disp_dest_prn(dest_prn), .disp_robn(tail_robn),
        .cdb_valid(cdb_valid), .cdb_prn(cdb_prn), .cdb_value(cdb_value),
        .alu_avail(alu_avail), .mult_avail(mult_avail),
        .alu_issue(alu_issue), .alu_op(alu_op), .alu_a(alu_a), .alu_b(alu_b),
        .alu_dest_prn(alu_dest_prn), .alu_robn(alu_robn),
        .mult_issue(mult_issue), .mult_a(mult_a), .mult_b(mult_b),
        .mult_dest_prn(mult_dest_prn), .mult_robn(mult_robn),
        .full(rs_full)
    );

    rob #(
        .arch_regs_p(arch_regs_p), .phys_regs_p(phys_regs_p), .rob_sz_p(rob_sz_p)
    ) u_rob (
        .clock(clock), .rst_n(rst_n), .disp(disp),
        .disp_arn(in_dest), .disp_prn(dest_prn), .tail_robn(tail_robn),
        .cdb_valid(cdb_valid), .cdb_robn(cdb_robn),
        .ct_valid(ct_valid), .ct_arn(ct_arn), .ct_prn(ct_prn), .full(rob_full)
    );

    fu_cdb #(
        .xlen_p(xlen_p), .phys_regs_p(phys_regs_p),
        .rob_sz_p(rob_sz_p), .mult_lat_p(mult_lat_p)
    ) u_fu_cdb (
        .clock(clock), .rst_n(rst_n),
        .alu_issue(alu_issue), .alu_op(alu_op), .alu_a(alu_a), .alu_b(alu_b),
        .alu_dest_prn(alu_dest_prn), .alu_robn(alu_robn),
        .mult_issue(mult_issue), .mult_a(mult_a), .mult_b(mult_b),
        .mult_dest_prn(mult_dest_prn), .mult_robn(mult_robn),
        .alu_avail(alu_avail), .mult_avail(mult_avail),
        .cdb_valid(cdb_valid), .cdb_prn(cdb_prn),
        .cdb_robn(cdb_robn), .cdb_value(cdb_value)
    );

endmodule

// ==== tb/ooo_tb.sv ====
`timescale 1ns/1ns
module ooo_tb;

    localparam int xlen  = ooo_pkg::xlen_p;
    localparam int arn_w = $clog2(ooo_pkg::arch_regs_p);

    logic              clock;
    logic              rst_n;
    logic              in_valid;
    ooo_pkg::alu_op_e  in_op;
    logic [arn_w-1:0]  in_dest, in_src1, in_src2;
    logic [xlen-1:0]   in_imm;
    logic              structural_hazard;
    logic              ct_valid, ct_wr_en;
    logic [arn_w-1:0]  ct_arn;
    logic [xlen-1:0]   ct_value;

    logic [31:0]       rng_state;
    logic [xlen-1:0]   arch [ooo_pkg::arch_regs_p];
    logic [arn_w-1:0]  exp_arn_q [$];
    logic [xlen-1:0]   exp_val_q [$];
    int                errors, accepted, committed;
    bit                timed_out, hazard_seen;
    string             phase_name;

    ooo u_ooo (
        .clock(clock), .rst_n(rst_n),
        .in_valid(in_valid), .in_op(in_op),
        .in_dest(in_dest), .in_src1(in_src1), .in_src2(in_src2), .in_imm(in_imm),
        .structural_hazard(structural_hazard),
        .ct_valid(ct_valid), .ct_wr_en(ct_wr_en),
        .ct_arn(ct_arn), .ct_value(ct_value)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("mismatch %s %s expected %0h actual %0h",
                     phase_name, name, expected, actual);
        end
    endtask

    // architectural reference, executes in program order
    task automatic model_exec(input ooo_pkg::alu_op_e op, input logic [arn_w-1:0] dest,
                              input logic [arn_w-1:0] src1, src2,
                              input logic [xlen-1:0] imm);
        logic [xlen-1:0]   a, b, result;
        logic [2*xlen-1:0] prod;
        a    = arch[src1];
        b    = arch[src2];
        prod = a * b;
        case (op)
            ooo_pkg::OP_ADD: result = a + b;
            ooo_pkg::OP_SUB: result = a - b;
            ooo_pkg::OP_AND: result = a & b;
            ooo_pkg::OP_XOR: result = a ^ b;
            ooo_pkg::OP_LI:  result = imm;
            default:         result = prod[xlen-1:0];
        endcase
        if (dest != '0) begin
            arch[dest] = result;
        end
        exp_arn_q.push_back(dest);
        exp_val_q.push_back(result);
    endtask

    // called right after a rising edge, returns at the edge of acceptance
    task automatic send_instr(input ooo_pkg::alu_op_e op, input logic [arn_w-1:0] dest,
                              input logic [arn_w-1:0] src1, src2,
                              input logic [xlen-1:0] imm);
        int waited;
        if (timed_out) begin
            return;
        end
        in_valid <= 1'b1;
        in_op    <= op;
        in_dest  <= dest;
        in_src1  <= src1;
        in_src2  <= src2;
        in_imm   <= imm;
        waited = 0;
        // hazard is stable mid cycle
        @(negedge clock);
        while (structural_hazard && waited < 200) begin
            hazard_seen = 1'b1;
            waited++;
            @(negedge clock);
        end
        if (structural_hazard) begin
            $display("timeout in %s, instruction never accepted", phase_name);
            errors++;
            timed_out = 1'b1;
            in_valid <= 1'b0;
            return;
        end
        @(posedge clock);
        model_exec(op, dest, src1, src2, imm);
        accepted++;
    endtask

    task automatic send_random();
        ooo_pkg::alu_op_e op;
        logic [arn_w-1:0] dest, src1, src2;
        logic [xlen-1:0]  imm;
        op   = ooo_pkg::alu_op_e'(3'(next_rand() % 6));
        dest = arn_w'(next_rand());
        src1 = arn_w'(next_rand());
        src2 = arn_w'(next_rand());
        imm  = xlen'(next_rand());
        send_instr(op, dest, src1, src2, imm);
    endtask

    task automatic drain();
        int waited;
        in_valid <= 1'b0;
        if (timed_out) begin
            return;
        end
        waited = 0;
        while (exp_arn_q.size() != 0 && waited < 400) begin
            waited++;
            @(posedge clock);
        end
        if (exp_arn_q.size() != 0) begin
            $display("timeout in %s, %0d commits still missing", phase_name, exp_arn_q.size());
            errors++;
            timed_out = 1'b1;
        end
        @(posedge clock);
        check("commit count", 32'(accepted), 32'(committed));
    endtask

    // commit checker, samples mid cycle
    always @(negedge clock) begin : commit_check
        logic [arn_w-1:0] arn;
        logic [xlen-1:0]  val;
        if (rst_n && ct_valid) begin
            committed++;
            if (exp_arn_q.size() == 0) begin
                $display("commit seen in %s with no instruction outstanding", phase_name);
                errors++;
            end else begin
                arn = exp_arn_q.pop_front();
                val = exp_val_q.pop_front();
                check("commit arn", 32'(arn), 32'(ct_arn));
                check("commit value", 32'(val), 32'(ct_value));
                check("commit wr_en", 32'(arn != '0), 32'(ct_wr_en));
            end
        end
    end

    initial begin
        logic [xlen-1:0] v;
        rst_n       = 1'b0;
        in_valid    = 1'b0;
        in_op       = ooo_pkg::OP_ADD;
        in_dest     = '0;
        in_src1     = '0;
        in_src2     = '0;
        in_imm      = '0;
        rng_state   = 32'd31590;
        errors      = 0;
        accepted    = 0;
        committed   = 0;
        timed_out   = 1'b0;
        hazard_seen = 1'b0;
        phase_name  = "reset";
        for (int r = 0; r < ooo_pkg::arch_regs_p; r++) begin
            arch[r] = '0;
        end
        repeat (3) @(posedge clock);
        rst_n <= 1'b1;
        @(negedge clock);
        check("ct_valid", 0, 32'(ct_valid));
        check("structural_hazard", 0, 32'(structural_hazard));
        repeat (10) @(posedge clock);
        check("idle commits", 0, 32'(committed));

        phase_name = "random mix";
        repeat (60) send_random();
        drain();

        // long multiply ahead of independent ALU work
        phase_name = "program order";
        v = xlen'(next_rand());
        send_instr(ooo_pkg::OP_LI, 3'd2, 3'd0, 3'd0, v);
        v = xlen'(next_rand());
        send_instr(ooo_pkg::OP_LI, 3'd3, 3'd0, 3'd0, v);
        send_instr(ooo_pkg::OP_MUL, 3'd1, 3'd2, 3'd3, '0);
        send_instr(ooo_pkg::OP_ADD, 3'd4, 3'd2, 3'd3, '0);
        send_instr(ooo_pkg::OP_XOR, 3'd5, 3'd3, 3'd2, '0);
        send_instr(ooo_pkg::OP_SUB, 3'd6, 3'd2, 3'd3, '0);
        send_instr(ooo_pkg::OP_AND, 3'd7, 3'd2, 3'd3, '0);
        send_instr(ooo_pkg::OP_ADD, 3'd0, 3'd4, 3'd5, '0);
        drain();

        phase_name  = "mul burst";
        hazard_seen = 1'b0;
        send_instr(ooo_pkg::OP_LI, 3'd1, 3'd0, 3'd0, 16'd3);
        v = xlen'(next_rand()) | 16'd1;
        send_instr(ooo_pkg::OP_LI, 3'd2, 3'd0, 3'd0, v);
        repeat (14) send_instr(ooo_pkg::OP_MUL, 3'd1, 3'd1, 3'd2, '0);
        drain();
        check("hazard seen", 1, 32'(hazard_seen));

        phase_name = "long random";
        repeat (300) send_random();
        drain();

        $display("errors %0d accepted %0d committed %0d", errors, accepted, committed);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== ooo.f ====
hdl/ooo_pkg.sv
hdl/rat.sv
hdl/rrat.sv
hdl/prf.sv
hdl/rs.sv
hdl/rob.sv
hdl/fu_cdb.sv
hdl/ooo.sv
tb/ooo_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module ooo_tb -f ooo.f -o ooo_sim \
    > build.log 2>&1 && ./obj_dir/ooo_sim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }
cat sim.log
grep -qx "TEST OK" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
